// File: qla_board.f
verilog/qla_addr_pkg.sv
verilog/qla_axis_pkg.sv
verilog/safety_check.sv
verilog/dac_spi.sv
verilog/dac_ctrl.sv
verilog/board_regs.sv
verilog/reg_read_mux.sv
verilog/qla_board.sv
tb/tb_qla_board.sv

// File: tb/tb_qla_board.sv
// testbench for the qla motor axis core
// drives the register bus, decodes dac frames and checks against reference models

`timescale 1ns/100ps

module tb_qla_board;
    import qla_addr_pkg::*;
    import qla_axis_pkg::*;

    localparam int MAX_CYCLES = 20000;   // tests take about 6000

    logic                 sysclk;
    logic                 arst_n;
    logic                 reg_wen;
    reg_addr_t            reg_waddr;
    reg_data_t            reg_wdata;
    reg_addr_t            reg_raddr;
    logic [3:0]           wenid;
    cur_t [NUM_AXES-1:0]  cur_fb;
    reg_data_t            reg_rdata;
    logic                 pwr_enable;
    logic                 relay_on;
    axis_bits_t           amp_disable;
    axis_bits_t           dout;
    logic                 dac_sclk;
    logic                 dac_mosi;
    logic                 dac_csel;

    integer seed = 32'hdea1_7d80;
    int     cycle_cnt = 0;
    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     errs_before = 0;
    string  cur_test = "reset";

    // reference model state
    logic       m_pwr = 1'b0;
    logic       m_relay = 1'b0;
    axis_bits_t m_amp = '0;
    axis_bits_t m_trip = '0;
    cur_t       m_cmd [NUM_AXES] = '{default: 16'h8000};

    // frame monitor
    logic [DAC_FRAME_BITS-1:0] exp_q [$];
    logic [DAC_FRAME_BITS-1:0] fbits = '0;
    int   nbits = 0;
    int   gap_cnt = 0;
    int   frames_seen = 0;
    logic prev_sclk = 1'b0;
    logic prev_csel = 1'b1;

    qla_board i_qla_board (.*);

    initial sysclk = 1'b0;
    always #20 sysclk = ~sysclk;   // 40 ns period

    always @(posedge sysclk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("run stopped: no result after %0d cycles in test %s", cycle_cnt, cur_test);
            $display(">>> FAIL");
            $finish;
        end
    end

    // --------------------
    // reference functions
    function automatic reg_data_t status_word(logic pwr, logic relay, axis_bits_t amp,
                                              axis_bits_t trip, logic [3:0] id);
        reg_data_t r;
        r                     = '0;
        r[ST_ID_LO +: 4]      = id;
        r[ST_PWR_VAL]         = pwr;
        r[ST_RELAY_VAL]       = relay;
        r[ST_SAFE_LO +: 4]    = trip;
        r[ST_AMP_LO +: 4]     = amp;
        return r;
    endfunction

    // pin high unless power on and axis enabled and not tripped
    function automatic axis_bits_t amp_pins(logic pwr, axis_bits_t amp, axis_bits_t trip);
        axis_bits_t dis;
        for (int i = 0; i < NUM_AXES; i++)
            dis[i] = !(pwr && amp[i] && !trip[i]);
        return dis;
    endfunction

    function automatic logic [DAC_FRAME_BITS-1:0] exp_frame(int axis, cur_t v);
        return {DAC_CMD_WRITE_UPDATE, 4'(axis), v};
    endfunction

    // feedback beyond 2*|cmd| + margin, magnitudes about midscale
    function automatic logic exp_over(cur_t fb, cur_t cmd);
        int fm;
        int cm;
        fm = int'(fb) - 32768;
        cm = int'(cmd) - 32768;
        if (fm < 0) fm = -fm;
        if (cm < 0) cm = -cm;
        return fm > 2 * cm + int'(SAFETY_MARGIN);
    endfunction

    function automatic reg_addr_t make_addr(logic [3:0] blk, logic [3:0] chan, logic [3:0] off);
        return {blk, 4'h0, chan, off};
    endfunction

    task automatic apply_status_model(input reg_data_t w);
        if (w[ST_PWR_MASK]) m_pwr = w[ST_PWR_VAL];
        if (w[ST_RELAY_MASK]) m_relay = w[ST_RELAY_VAL];
        if (w[ST_PWR_MASK] && !w[ST_PWR_VAL])
            m_amp = '0;   // power off drops every amp
        else
            m_amp = (m_amp & ~w[ST_SAFE_LO +: 4]) | (w[ST_AMP_LO +: 4] & w[ST_SAFE_LO +: 4]);
        if (w[ST_PWR_MASK] && w[ST_PWR_VAL])
            m_trip = '0;
        m_trip = m_trip & ~(w[ST_SAFE_LO +: 4] & w[ST_AMP_LO +: 4]);
    endtask

    // --------------------
    // compare tasks
    task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s %s: expected %h, actual %h", cur_test, name, exp, act);
        end
    endtask

    task automatic check_bits(input string name, input axis_bits_t exp, input axis_bits_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s %s: expected %b, actual %b", cur_test, name, exp, act);
        end
    endtask

    task automatic check_frame(input string name, input logic [DAC_FRAME_BITS-1:0] exp,
                               input logic [DAC_FRAME_BITS-1:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s %s: expected %h, actual %h", cur_test, name, exp, act);
        end
    endtask

    // --------------------
    // bus tasks, called 2 ns after a rising edge and return at the same point
    task automatic bus_write(input reg_addr_t a, input reg_data_t d);
        reg_wen   = 1'b1;
        reg_waddr = a;
        reg_wdata = d;
        @(posedge sysclk);
        #2;
        reg_wen   = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t a, output reg_data_t d);
        reg_raddr = a;
        @(posedge sysclk);   // address sampled here, data registered
        #2;
        d = reg_rdata;
    endtask

    task automatic check_board(input string name);
        reg_data_t rd;
        bus_read(make_addr(ADDR_MAIN, 4'd0, REG_STATUS), rd);
        check_data({name, " status"}, status_word(m_pwr, m_relay, m_amp, m_trip, ~wenid), rd);
        check_bits({name, " pwr/relay"}, {2'b00, m_relay, m_pwr}, {2'b00, relay_on, pwr_enable});
        check_bits({name, " amp_disable"}, amp_pins(m_pwr, m_amp, m_trip), amp_disable);
    endtask

    task automatic wait_frames();
        while (exp_q.size() != 0)
            @(negedge sysclk);
        repeat (60) @(posedge sysclk);   // longer than a frame, catches any extra one
        #2;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %-14s %s, %0d errors", cur_test,
                 (errors == errs_before) ? "ok" : "errors seen", errors - errs_before);
        errs_before = errors;
    endtask

    // --------------------
    // dac frame monitor, bits taken where sclk has risen
    always @(negedge sysclk) begin
        if (arst_n) begin
            if (!dac_csel) begin
                if (prev_csel) begin   // frame start
                    if (frames_seen > 0 && gap_cnt < 2) begin
                        errors++;
                        $display("DAC frame started after only %0d idle cycles", gap_cnt);
                    end
                    nbits = 0;
                    fbits = '0;
                end
                if (dac_sclk && !prev_sclk) begin
                    fbits = {fbits[DAC_FRAME_BITS-2:0], dac_mosi};
                    nbits++;
                end
            end else if (!prev_csel) begin   // csel rose, frame done
                frames_seen++;
                gap_cnt = 0;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("unexpected DAC frame %h in test %s", fbits, cur_test);
                end else if (nbits != DAC_FRAME_BITS) begin
                    errors++;
                    void'(exp_q.pop_front());
                    $display("DAC frame had %0d bits instead of %0d", nbits, DAC_FRAME_BITS);
                end else begin
                    check_frame("frame", exp_q.pop_front(), fbits);
                end
            end
            if (dac_csel)
                gap_cnt++;
        end
        prev_csel = dac_csel;
        prev_sclk = dac_sclk;
    end

    // --------------------
    // test sequence
    initial begin
        reg_data_t rd;
        reg_data_t w;
        cur_t      v;
        cur_t      vals [NUM_AXES];
        int        ax;
        int        lim;

        arst_n    = 1'b0;
        reg_wen   = 1'b0;
        reg_waddr = '0;
        reg_wdata = '0;
        reg_raddr = '0;
        wenid     = 4'b1010;
        cur_fb    = {NUM_AXES{16'h8000}};
        repeat (4) @(posedge sysclk);
        #2;
        arst_n = 1'b1;

        // 1. reset state
        cur_test = "reset";
        check_board("initial");
        check_bits("dout", 4'b0000, dout);
        checks++;
        if (dac_csel !== 1'b1) begin
            errors++;
            $display("dac_csel is not high after reset");
        end
        bus_read(make_addr(ADDR_MAIN, 4'd0, REG_IDVER), rd);
        check_data("idver", HW_VERSION, rd);
        end_test();

        // 2. board registers
        cur_test = "board_regs";
        w = 32'h000C_0F0F;   // power on, all amps on
        bus_write(make_addr(ADDR_MAIN, 4'd0, REG_STATUS), w);
        apply_status_model(w);
        check_board("all on");
        w = 32'h0008_0000;   // power off only
        bus_write(make_addr(ADDR_MAIN, 4'd0, REG_STATUS), w);
        apply_status_model(w);
        check_board("power off");
        for (int i = 0; i < 24; i++) begin
            w = $random(seed);
            bus_write(make_addr(ADDR_MAIN, 4'd0, REG_STATUS), w);
            apply_status_model(w);
            check_board("random status");
        end
        for (int i = 0; i < 6; i++) begin
            w = $random(seed);
            bus_write(make_addr(ADDR_MAIN, 4'd0, REG_DIGIOUT), w);
            bus_read(make_addr(ADDR_MAIN, 4'd0, REG_DIGIOUT), rd);
            check_bits("dout pins", w[3:0], dout);
            check_data("digiout read", {28'h0, w[3:0]}, rd);
        end
        end_test();

        // 3. single dac command
        cur_test = "dac_single";
        for (int i = 0; i < 4; i++) begin
            ax = $unsigned($random(seed)) % NUM_AXES;
            v  = $random(seed);
            exp_q.push_back(exp_frame(ax, v));
            m_cmd[ax] = v;
            bus_write(make_addr(ADDR_MAIN, 4'(ax + 1), OFF_DAC_CTRL), {16'h0, v});
            bus_read(make_addr(ADDR_MAIN, 4'(ax + 1), OFF_DAC_CTRL), rd);
            check_data("cmd readback", {16'h0, m_cmd[ax]}, rd);
            wait_frames();
        end
        end_test();

        // 4. back-pressure, axis 0 first then 3, 2, 1
        cur_test = "dac_queue";
        for (int i = 0; i < NUM_AXES; i++) begin
            vals[i]  = $random(seed);
            m_cmd[i] = vals[i];
            exp_q.push_back(exp_frame(i, vals[i]));   // always ascending
        end
        bus_write(make_addr(ADDR_MAIN, 4'd1, OFF_DAC_CTRL), {16'h0, vals[0]});
        for (int i = NUM_AXES - 1; i >= 1; i--)
            bus_write(make_addr(ADDR_MAIN, 4'(i + 1), OFF_DAC_CTRL), {16'h0, vals[i]});
        wait_frames();
        vals[0] = $random(seed);
        vals[1] = $random(seed);
        vals[2] = $random(seed);   // overwrites vals[1] before it goes out
        m_cmd[0] = vals[0];
        m_cmd[2] = vals[2];
        exp_q.push_back(exp_frame(0, vals[0]));
        exp_q.push_back(exp_frame(2, vals[2]));
        bus_write(make_addr(ADDR_MAIN, 4'd1, OFF_DAC_CTRL), {16'h0, vals[0]});
        bus_write(make_addr(ADDR_MAIN, 4'd3, OFF_DAC_CTRL), {16'h0, vals[1]});
        bus_write(make_addr(ADDR_MAIN, 4'd3, OFF_DAC_CTRL), {16'h0, vals[2]});
        wait_frames();
        end_test();

        // 5. safety trip and clear on axis index 1
        cur_test = "safety";
        w = 32'h000C_0F0F;
        bus_write(make_addr(ADDR_MAIN, 4'd0, REG_STATUS), w);
        apply_status_model(w);
        v = 16'h8000 - 16'h0300;   // command magnitude 0x300
        m_cmd[1] = v;
        exp_q.push_back(exp_frame(1, v));
        bus_write(make_addr(ADDR_MAIN, 4'd2, OFF_DAC_CTRL), {16'h0, v});
        wait_frames();
        lim = 2 * 16'h0300 + int'(SAFETY_MARGIN);
        cur_fb[1] = 16'(32768 + lim);   // right at the limit
        repeat (100) @(posedge sysclk);
        #2;
        for (int i = 0; i < NUM_AXES; i++)
            if (exp_over(cur_fb[i], m_cmd[i])) m_trip[i] = 1'b1;
        check_board("within limit");
        cur_fb[1] = 16'(32768 + lim + 1);
        repeat (100) @(posedge sysclk);
        #2;
        for (int i = 0; i < NUM_AXES; i++)
            if (exp_over(cur_fb[i], m_cmd[i])) m_trip[i] = 1'b1;
        check_board("over limit");
        cur_fb[1] = 16'h8000;
        w = 32'h0000_0202;   // re-enable amp for axis index 1
        bus_write(make_addr(ADDR_MAIN, 4'd0, REG_STATUS), w);
        apply_status_model(w);
        check_board("cleared");
        end_test();

        // 6. read decode
        cur_test = "read_decode";
        for (int i = 0; i < NUM_AXES; i++)
            cur_fb[i] = $random(seed);
        for (int i = 0; i < NUM_AXES; i++) begin
            bus_read(make_addr(ADDR_MAIN, 4'(i + 1), OFF_ADC_DATA), rd);
            check_data("adc readback", {16'h0, cur_fb[i]}, rd);
        end
        bus_read(make_addr(4'h1, 4'd0, REG_STATUS), rd);
        check_data("block 1", '0, rd);
        bus_read(make_addr(4'hF, 4'd1, OFF_ADC_DATA), rd);
        check_data("block f", '0, rd);
        bus_read(make_addr(ADDR_MAIN, 4'd0, 4'd3), rd);
        check_data("board offset 3", '0, rd);
        bus_read(make_addr(ADDR_MAIN, 4'd2, 4'd2), rd);
        check_data("axis offset 2", '0, rd);
        bus_read(make_addr(ADDR_MAIN, 4'd5, OFF_ADC_DATA), rd);
        check_data("channel 5", '0, rd);
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/board_regs.sv
// channel 0 board registers
// power, relay, amp enables and digital outputs, masked status writes
// amp disable pins combine power, enables and safety trips

`timescale 1ns/100ps

module board_regs (
    input  logic                       sysclk,
    input  logic                       arst_n,
    input  logic                       reg_wen,
    input  qla_addr_pkg::reg_addr_t    reg_waddr,
    input  qla_addr_pkg::reg_data_t    reg_wdata,
    input  logic [3:0]                 wenid,
    input  qla_axis_pkg::axis_bits_t   safety_disable,
    output qla_addr_pkg::reg_data_t    status_data,
    output qla_axis_pkg::axis_bits_t   digiout_data,
    output qla_axis_pkg::axis_bits_t   clear_disable,
    output logic                       pwr_enable,
    output logic                       relay_on,
    output qla_axis_pkg::axis_bits_t   amp_disable,
    output qla_axis_pkg::axis_bits_t   dout
);
    import qla_addr_pkg::*;
    import qla_axis_pkg::*;

    logic       chan0_wr;
    logic       status_wr;
    logic       digiout_wr;
    logic       pwr_on_wr;     // power enable write, clears all trips
    logic       pwr_off_wr;
    axis_bits_t amp_mask;
    axis_bits_t amp_val;
    axis_bits_t amp_on_wr;     // per-axis enable writes
    axis_bits_t amp_en;

    // --------------------
    // write decode
    assign chan0_wr   = reg_wen && (reg_waddr[15:12] == ADDR_MAIN) && (reg_waddr[7:4] == 4'd0);
    assign status_wr  = chan0_wr && (reg_waddr[3:0] == REG_STATUS);
    assign digiout_wr = chan0_wr && (reg_waddr[3:0] == REG_DIGIOUT);

    assign amp_mask   = reg_wdata[ST_SAFE_LO +: NUM_AXES];
    assign amp_val    = reg_wdata[ST_AMP_LO +: NUM_AXES];
    assign pwr_on_wr  = status_wr && reg_wdata[ST_PWR_MASK] && reg_wdata[ST_PWR_VAL];
    assign pwr_off_wr = status_wr && reg_wdata[ST_PWR_MASK] && !reg_wdata[ST_PWR_VAL];
    assign amp_on_wr  = status_wr ? (amp_mask & amp_val) : '0;

    assign clear_disable = {NUM_AXES{pwr_on_wr}} | amp_on_wr;

    // --------------------
    // control registers
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            pwr_enable <= 1'b0;
            relay_on   <= 1'b0;
            amp_en     <= '0;
            dout       <= '0;
        end else begin
            if (status_wr) begin
                if (reg_wdata[ST_PWR_MASK])
                    pwr_enable <= reg_wdata[ST_PWR_VAL];
                if (reg_wdata[ST_RELAY_MASK])
                    relay_on <= reg_wdata[ST_RELAY_VAL];
                if (pwr_off_wr)
                    amp_en <= '0;                                // power off drops every amp
                else
                    amp_en <= (amp_en & ~amp_mask) | (amp_val & amp_mask);
            end
            if (digiout_wr)
                dout <= reg_wdata[NUM_AXES-1:0];
        end
    end

    // amp runs only with power on, enabled and not tripped
    assign amp_disable = ~({NUM_AXES{pwr_enable}} & amp_en & ~safety_disable);

    // --------------------
    // readback
    always_comb begin
        status_data                          = '0;
        status_data[ST_ID_LO +: 4]           = ~wenid;   // switch is active low
        status_data[ST_PWR_VAL]              = pwr_enable;
        status_data[ST_RELAY_VAL]            = relay_on;
        status_data[ST_SAFE_LO +: NUM_AXES]  = safety_disable;
        status_data[ST_AMP_LO +: NUM_AXES]   = amp_en;
    end

    assign digiout_data = dout;

endmodule

// File: verilog/dac_ctrl.sv
// current command registers
// queues one dac update per written axis, lowest pending axis goes first

`timescale 1ns/100ps

module dac_ctrl (
    input  logic                                             sysclk,
    input  logic                                             arst_n,
    input  logic                                             reg_wen,
    input  qla_addr_pkg::reg_addr_t                          reg_waddr,
    input  qla_addr_pkg::reg_data_t                          reg_wdata,
    output qla_axis_pkg::cur_t [qla_axis_pkg::NUM_AXES-1:0]  cur_cmd,
    output logic                                             dac_sclk,
    output logic                                             dac_mosi,
    output logic                                             dac_csel
);
    import qla_addr_pkg::*;
    import qla_axis_pkg::*;

    logic       cmd_wr;
    logic [1:0] wr_axis;
    axis_bits_t pending;     // written but not yet sent
    logic       busy;
    logic       load;
    logic [1:0] load_axis;

    assign wr_axis = 2'(reg_waddr[7:4] - 4'd1);
    assign cmd_wr  = reg_wen && (reg_waddr[15:12] == ADDR_MAIN) && (reg_waddr[7:4] != 4'd0)
                     && (reg_waddr[7:4] <= 4'(NUM_AXES)) && (reg_waddr[3:0] == OFF_DAC_CTRL);

    // lowest pending axis wins
    always_comb begin
        load_axis = '0;
        for (int i = NUM_AXES - 1; i >= 0; i--) begin
            if (pending[i])
                load_axis = 2'(i);
        end
    end

    assign load = !busy && (pending != '0);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            cur_cmd <= {NUM_AXES{CUR_MID}};   // zero current
            pending <= '0;
        end else begin
            if (cmd_wr)
                cur_cmd[wr_axis] <= reg_wdata[15:0];
            // a write landing with its own load stays pending, so the new value still goes out
            pending <= (pending & ~(load ? axis_bits_t'(1) << load_axis : '0))
                       | (cmd_wr ? axis_bits_t'(1) << wr_axis : '0);
        end
    end

    dac_spi i_dac_spi (
        .sysclk     (sysclk),
        .arst_n     (arst_n),
        .load       (load),
        .load_axis  (load_axis),
        .load_value (cur_cmd[load_axis]),
        .busy       (busy),
        .sclk       (dac_sclk),
        .mosi       (dac_mosi),
        .csel       (dac_csel)
    );

endmodule

// File: verilog/dac_spi.sv
// dac serial shifter
// sends one 24-bit frame msb first, two cycles per bit, then a short csel-high gap

`timescale 1ns/100ps

module dac_spi (
    input  logic               sysclk,
    input  logic               arst_n,
    input  logic               load,         // start a frame, taken only when idle
    input  logic [1:0]         load_axis,
    input  qla_axis_pkg::cur_t load_value,
    output logic               busy,
    output logic               sclk,
    output logic               mosi,
    output logic               csel
);
    import qla_axis_pkg::*;

    localparam logic [4:0] LAST_BIT = 5'(DAC_FRAME_BITS - 1);
    localparam logic [4:0] GAP_LEN  = 5'd2;   // idle cycles with csel high

    dac_state_e                state;
    logic [DAC_FRAME_BITS-1:0] shreg;
    logic [4:0]                cnt;     // bit index while shifting, gap cycles after
    logic                      phase;   // 0 sclk low, 1 sclk high

    assign busy = (state != DAC_IDLE);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= DAC_IDLE;
            shreg <= '0;
            cnt   <= '0;
            phase <= 1'b0;
            sclk  <= 1'b0;
            mosi  <= 1'b0;
            csel  <= 1'b1;
        end else begin
            case (state)
                DAC_IDLE: begin
                    if (load) begin
                        shreg <= {DAC_CMD_WRITE_UPDATE, 2'b00, load_axis, load_value};
                        state <= DAC_LOAD;
                    end
                end
                DAC_LOAD: begin
                    csel  <= 1'b0;
                    mosi  <= shreg[DAC_FRAME_BITS-1];   // first bit set up with sclk low
                    cnt   <= '0;
                    phase <= 1'b0;
                    state <= DAC_SHIFT;
                end
                DAC_SHIFT: begin
                    phase <= ~phase;
                    if (!phase) begin
                        sclk <= 1'b1;   // rising edge mid-bit
                    end else begin
                        sclk <= 1'b0;
                        if (cnt == LAST_BIT) begin
                            csel  <= 1'b1;   // frame done
                            mosi  <= 1'b0;
                            cnt   <= '0;
                            state <= DAC_GAP;
                        end else begin
                            shreg <= shreg << 1;
                            mosi  <= shreg[DAC_FRAME_BITS-2];
                            cnt   <= cnt + 5'd1;
                        end
                    end
                end
                DAC_GAP: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == GAP_LEN - 5'd1)
                        state <= DAC_IDLE;
                end
                default: state <= DAC_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/qla_addr_pkg.sv
// qla register map
// bus widths, block and channel decode, register offsets and status bit positions

package qla_addr_pkg;

    // --------------------
    // bus types
    typedef logic [15:0] reg_addr_t;   // [15:12] block, [7:4] channel, [3:0] offset
    typedef logic [31:0] reg_data_t;

    localparam logic [3:0] ADDR_MAIN = 4'd0;   // only block with registers behind it

    // axis channel offsets, channels 1..4
    typedef enum logic [3:0] {
        OFF_ADC_DATA = 4'd0,   // current feedback
        OFF_DAC_CTRL = 4'd1    // current command
    } chan_off_e;

    // board channel offsets, channel 0
    typedef enum logic [3:0] {
        REG_STATUS  = 4'd0,
        REG_DIGIOUT = 4'd1,
        REG_IDVER   = 4'd2
    } board_off_e;

    // --------------------
    // status word layout
    localparam logic [4:0] ST_PWR_MASK   = 5'd19;
    localparam logic [4:0] ST_PWR_VAL    = 5'd18;
    localparam logic [4:0] ST_RELAY_MASK = 5'd17;
    localparam logic [4:0] ST_RELAY_VAL  = 5'd16;
    localparam logic [4:0] ST_SAFE_LO    = 5'd8;    // trips on read, amp masks on write
    localparam logic [4:0] ST_AMP_LO     = 5'd0;    // amp enable values
    localparam logic [4:0] ST_ID_LO      = 5'd24;   // rotary switch id

    // firmware tag, "QLA1"
    localparam reg_data_t HW_VERSION = 32'h514C_4131;

endpackage

// File: verilog/qla_axis_pkg.sv
// qla axis definitions
// current encoding, dac frame format and overcurrent check limits

package qla_axis_pkg;

    localparam int NUM_AXES = 4;

    // --------------------
    // current values, offset binary
    typedef logic [15:0] cur_t;
    localparam cur_t CUR_MID = 16'h8000;   // zero current

    typedef logic [NUM_AXES-1:0] axis_bits_t;   // bit 0 is axis 1

    // --------------------
    // dac serial frame: cmd nibble, axis index nibble, 16-bit value
    localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'd3;
    localparam int         DAC_FRAME_BITS       = 24;

    typedef enum logic [1:0] {
        DAC_IDLE,    // csel high, waiting for load
        DAC_LOAD,    // drop csel, first bit out
        DAC_SHIFT,   // two cycles per bit
        DAC_GAP      // csel high before the next frame
    } dac_state_e;

    // --------------------
    // safety limit is 2*|cmd| + margin, held for SAFETY_COUNT cycles
    localparam logic [15:0] SAFETY_MARGIN = 16'h0100;
    localparam logic [4:0]  SAFETY_COUNT  = 5'd16;

endpackage

// File: verilog/qla_board.sv
// qla motor axis core, top level
// register bus, board registers, dac command path and per-axis overcurrent checks

`timescale 1ns/100ps

module qla_board (
    input  logic                                             sysclk,
    input  logic                                             arst_n,
    input  logic                                             reg_wen,     // one-cycle write strobe
    input  qla_addr_pkg::reg_addr_t                          reg_waddr,
    input  qla_addr_pkg::reg_data_t                          reg_wdata,
    input  qla_addr_pkg::reg_addr_t                          reg_raddr,   // free running
    input  logic [3:0]                                       wenid,       // rotary switch
    input  qla_axis_pkg::cur_t [qla_axis_pkg::NUM_AXES-1:0]  cur_fb,
    output qla_addr_pkg::reg_data_t                          reg_rdata,
    output logic                                             pwr_enable,
    output logic                                             relay_on,
    output qla_axis_pkg::axis_bits_t                         amp_disable,
    output qla_axis_pkg::axis_bits_t                         dout,
    output logic                                             dac_sclk,
    output logic                                             dac_mosi,
    output logic                                             dac_csel
);
    import qla_addr_pkg::*;
    import qla_axis_pkg::*;

    reg_data_t                status_data;
    axis_bits_t               digiout_data;
    axis_bits_t               clear_disable;    // power or amp enable pulse per axis
    axis_bits_t               safety_disable;   // sticky trips
    cur_t [NUM_AXES-1:0]      cur_cmd;

    // --------------------
    // read path
    reg_read_mux i_reg_read_mux (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .reg_raddr    (reg_raddr),
        .status_data  (status_data),
        .digiout_data (digiout_data),
        .cur_fb       (cur_fb),
        .cur_cmd      (cur_cmd),
        .reg_rdata    (reg_rdata)
    );

    // --------------------
    // channel 0
    board_regs i_board_regs (
        .sysclk         (sysclk),
        .arst_n         (arst_n),
        .reg_wen        (reg_wen),
        .reg_waddr      (reg_waddr),
        .reg_wdata      (reg_wdata),
        .wenid          (wenid),
        .safety_disable (safety_disable),
        .status_data    (status_data),
        .digiout_data   (digiout_data),
        .clear_disable  (clear_disable),
        .pwr_enable     (pwr_enable),
        .relay_on       (relay_on),
        .amp_disable    (amp_disable),
        .dout           (dout)
    );

    // --------------------
    // current commands and dac
    dac_ctrl i_dac_ctrl (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .cur_cmd   (cur_cmd),
        .dac_sclk  (dac_sclk),
        .dac_mosi  (dac_mosi),
        .dac_csel  (dac_csel)
    );

    // --------------------
    // one overcurrent check per axis
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_safe
        safety_check i_safety_check (
            .sysclk  (sysclk),
            .arst_n  (arst_n),
            .cur_in  (cur_fb[i]),
            .cmd_in  (cur_cmd[i]),
            .clear   (clear_disable[i]),
            .tripped (safety_disable[i])
        );
    end

endmodule

// File: verilog/reg_read_mux.sv
// register read decode
// selects board, axis feedback or command data by address, one cycle latency

`timescale 1ns/100ps

module reg_read_mux (
    input  logic                                             sysclk,
    input  logic                                             arst_n,
    input  qla_addr_pkg::reg_addr_t                          reg_raddr,
    input  qla_addr_pkg::reg_data_t                          status_data,
    input  qla_axis_pkg::axis_bits_t                         digiout_data,
    input  qla_axis_pkg::cur_t [qla_axis_pkg::NUM_AXES-1:0]  cur_fb,
    input  qla_axis_pkg::cur_t [qla_axis_pkg::NUM_AXES-1:0]  cur_cmd,
    output qla_addr_pkg::reg_data_t                          reg_rdata
);
    import qla_addr_pkg::*;
    import qla_axis_pkg::*;

    logic [3:0] blk;
    logic [3:0] chan;
    logic [3:0] off;
    logic [1:0] axis_idx;   // channel 1..4 -> 0..3
    logic       is_axis;
    reg_data_t  rd_next;

    assign blk      = reg_raddr[15:12];
    assign chan     = reg_raddr[7:4];
    assign off      = reg_raddr[3:0];
    assign axis_idx = 2'(chan - 4'd1);
    assign is_axis  = (chan != 4'd0) && (chan <= 4'(NUM_AXES));

    always_comb begin
        rd_next = '0;   // unmapped and other blocks read zero
        if (blk == ADDR_MAIN) begin
            if (chan == 4'd0) begin
                case (off)
                    REG_STATUS:  rd_next = status_data;
                    REG_DIGIOUT: rd_next = {{(32-NUM_AXES){1'b0}}, digiout_data};
                    REG_IDVER:   rd_next = HW_VERSION;
                    default:     rd_next = '0;
                endcase
            end else if (is_axis) begin
                case (off)
                    OFF_ADC_DATA: rd_next = {16'h0000, cur_fb[axis_idx]};
                    OFF_DAC_CTRL: rd_next = {16'h0000, cur_cmd[axis_idx]};
                    default:      rd_next = '0;
                endcase
            end
        end
    end

    // registered read data
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            reg_rdata <= '0;
        end else begin
            reg_rdata <= rd_next;
        end
    end

endmodule

// File: verilog/safety_check.sv
// overcurrent check for one axis
// trips when |fb| > 2*|cmd| + margin for SAFETY_COUNT cycles in a row, sticky until clear

`timescale 1ns/100ps

module safety_check (
    input  logic               sysclk,
    input  logic               arst_n,
    input  qla_axis_pkg::cur_t cur_in,    // feedback
    input  qla_axis_pkg::cur_t cmd_in,    // command
    input  logic               clear,
    output logic               tripped
);
    import qla_axis_pkg::*;

    logic [15:0] cur_mag;
    logic [15:0] cmd_mag;
    logic [17:0] limit;   // room for 2*0x8000 + margin
    logic        over;
    logic [4:0]  over_cnt;

    // magnitudes about midscale
    assign cur_mag = (cur_in >= CUR_MID) ? cur_in - CUR_MID : CUR_MID - cur_in;
    assign cmd_mag = (cmd_in >= CUR_MID) ? cmd_in - CUR_MID : CUR_MID - cmd_in;
    assign limit   = {1'b0, cmd_mag, 1'b0} + {2'b00, SAFETY_MARGIN};
    assign over    = {2'b00, cur_mag} > limit;

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            over_cnt <= '0;
            tripped  <= 1'b0;
        end else if (clear) begin   // clear beats a trip in the same cycle
            over_cnt <= '0;
            tripped  <= 1'b0;
        end else if (!over) begin
            over_cnt <= '0;         // any in-limit cycle restarts the count
        end else if (over_cnt == SAFETY_COUNT - 5'd1) begin
            tripped  <= 1'b1;       // count holds here while over
        end else begin
            over_cnt <= over_cnt + 5'd1;
        end
    end

endmodule
